// ==== vlog.f ====
cpu_ctl_pkg.sv
insn_fetch.sv
insn_decode.sv
step_execute.sv
ctl_result.sv
cpu_ctl_top.sv
tb_cpu_ctl.sv

// ==== Makefile ====
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall --timing
TOP        = tb_cpu_ctl
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator output is logged and searched for the pass line
run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_cpu_ctl.sv ====
`timescale 1ns/1ns

module tb_cpu_ctl import cpu_ctl_pkg::*; ();

    localparam int num_tests = 6;

    // One instruction of the program, with the data bytes a load reads back
    typedef struct packed {
        logic [2:0]        test;
        logic [insn_w-1:0] bytes;
        logic [byte_w-1:0] load_lo;
        logic [byte_w-1:0] load_hi;
    } insn_rec_t;

    typedef ctl_word_t word_q_t[$];

    logic              clk = 1'b0;
    logic              reset;
    logic [byte_w-1:0] byte_in;
    ctl_word_t         ctl;
    logic              busy_fetch;

    insn_rec_t prog_q[$];
    ctl_word_t exp_q[$];
    int        tag_q[$];
    int        checks[num_tests];
    int        errors[num_tests];
    string     test_names[num_tests];
    int        cycle_cnt = 0;
    int        cycle_limit;
    logic      check_en;
    ctl_word_t exp_word;
    int        exp_tag;

    cpu_ctl_top dut_i (
        .clk        (clk),
        .reset      (reset),
        .byte_in    (byte_in),
        .ctl        (ctl),
        .busy_fetch (busy_fetch)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int insn_length(logic [op_w-1:0] op);
        if (op <= 4'd1) begin
            return 1;
        end else if (op <= 4'd6) begin
            return 2;
        end else if (op <= 4'd9) begin
            return 3;
        end
        return 4;
    endfunction

    function automatic logic [num_regs-1:0] reg_bit(logic [3:0] r);
        logic [num_regs-1:0] v;
        v    = '0;
        v[r] = 1'b1;
        return v;
    endfunction

    // Bus 0 is A, 1 is B and 2 is C inside each register's group of three
    function automatic logic [oe_w-1:0] oe_for(logic [3:0] r, int bus);
        logic [oe_w-1:0] v;
        v = '0;
        v[int'(r) * oe_bits_per_reg + bus] = 1'b1;
        return v;
    endfunction

    // Every control word the DUT should show for one instruction, in order
    function automatic word_q_t expected_words(insn_rec_t rec);
        word_q_t           q;
        ctl_word_t         w;
        ctl_word_t         fetch;
        logic [3:0]        op;
        logic [3:0]        ra;
        logic [3:0]        rb;
        logic [3:0]        rc;
        logic [data_w-1:0] lo_imm;
        logic [data_w-1:0] hi_imm;
        int                i;
        op              = rec.bytes[7:4];
        ra              = rec.bytes[3:0];
        rc              = rec.bytes[11:8];
        rb              = rec.bytes[15:12];
        lo_imm          = rec.bytes[23:8];
        hi_imm          = rec.bytes[31:16];
        fetch           = '0;
        fetch.write_en  = reg_bit(4'd0);
        fetch.alu_op    = alu_add;
        fetch.output_en = oe_for(4'd0, 0);
        fetch.ctl_out   = steer_fetch;
        fetch.immediate = fetch_imm;
        for (i = 0; i < insn_length(op); i++) begin
            q.push_back(fetch);
        end
        // Decode cycle shows nothing
        q.push_back('0);
        w = '0;
        case (op)
            op_lfun_rr: begin
                w.write_en       = reg_bit(ra);
                w.output_en      = oe_for(ra, 0) | oe_for(rb, 1);
                w.alu_op         = alu_logic;
                w.alu_logic_func = rc;
                w.ctl_out        = steer_rr;
            end
            op_add_rr, op_sub_rr, op_rot_rr: begin
                w.write_en       = reg_bit(rb);
                w.output_en      = oe_for(rb, 0) | oe_for(rc, 1);
                w.alu_op         = (op == op_add_rr) ? alu_add :
                                   (op == op_sub_rr) ? alu_sub : alu_rot;
                w.alu_logic_func = rc;
                w.ctl_out        = steer_rr;
            end
            op_rot_ri, op_add_ri: begin
                w.write_en  = reg_bit(ra);
                w.output_en = oe_for(ra, 0);
                w.alu_op    = (op == op_rot_ri) ? alu_rot : alu_add;
                w.ctl_out   = steer_ri;
                w.immediate = (op == op_rot_ri) ? {12'd0, rc} : lo_imm;
            end
            op_mov_ri: begin
                w.write_en  = reg_bit(ra);
                w.ctl_out   = steer_imm_to_reg;
                w.immediate = lo_imm;
            end
            op_lfun_ri: begin
                w.write_en       = reg_bit(rb);
                w.output_en      = oe_for(rb, 0);
                w.alu_op         = alu_logic;
                w.alu_logic_func = rc;
                w.ctl_out        = steer_ri;
                w.immediate      = hi_imm;
            end
            op_bez, op_bnez, op_bgez: begin
                w.write_en  = reg_bit(4'd0);
                w.output_en = oe_for(rc, 0) | oe_for(rb, 2);
                w.alu_op    = (op == op_bez) ? alu_bez : (op == op_bnez) ? alu_bnez : alu_bgez;
                w.ctl_out   = steer_ri;
                w.immediate = hi_imm;
            end
            op_load: begin
                w.alu_op     = alu_add;
                w.output_en  = oe_for(rc, 0);
                w.ctl_out    = steer_load_addr;
                w.immediate2 = hi_imm;
                q.push_back(w);
                w.alu_op = alu_add_carry;
                q.push_back(w);
                w           = '0;
                w.write_en  = reg_bit(rb);
                w.ctl_out   = steer_imm_to_reg;
                w.immediate = {rec.load_hi, rec.load_lo};
            end
            op_store: begin
                w.data_write_en = 1'b1;
                w.alu_op        = alu_add;
                w.output_en     = oe_for(rb, 0) | oe_for(rc, 1);
                w.ctl_out       = steer_store_lo;
                w.immediate     = hi_imm;
                q.push_back(w);
                w.alu_op  = alu_add_carry;
                w.ctl_out = steer_store_hi;
            end
            // PUSH, POP and CALL run one empty step
            default: ;
        endcase
        q.push_back(w);
        return q;
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    function automatic insn_rec_t make_insn(int test, logic [3:0] op);
        insn_rec_t rec;
        int        i;
        rec.test       = 3'(test);
        rec.bytes      = $urandom;
        rec.bytes[7:4] = op;
        for (i = insn_length(op); i < 4; i++) begin
            rec.bytes[i*byte_w +: byte_w] = '0;
        end
        rec.load_lo = 8'($urandom);
        rec.load_hi = 8'($urandom);
        return rec;
    endfunction

    task automatic build_program();
        insn_rec_t rec;
        int        k;
        // MOV R5,#0x1234 and a four-byte LFUN with immediate 0xbeef
        rec       = make_insn(0, op_mov_ri);
        rec.bytes = 32'h0012_3485;
        prog_q.push_back(rec);
        rec       = make_insn(0, op_lfun_ri);
        rec.bytes = 32'hbeef_36a0;
        prog_q.push_back(rec);
        // Each test's instructions stay together so its words end before the next begins
        for (k = 0; k < 3; k++) begin
            prog_q.push_back(make_insn(1, op_lfun_rr));
            prog_q.push_back(make_insn(1, op_add_rr));
            prog_q.push_back(make_insn(1, op_sub_rr));
            prog_q.push_back(make_insn(1, op_rot_rr));
        end
        for (k = 0; k < 3; k++) begin
            prog_q.push_back(make_insn(2, op_rot_ri));
            prog_q.push_back(make_insn(2, op_add_ri));
            prog_q.push_back(make_insn(2, op_mov_ri));
            prog_q.push_back(make_insn(2, op_lfun_ri));
        end
        for (k = 0; k < 3; k++) begin
            prog_q.push_back(make_insn(3, op_bez));
            prog_q.push_back(make_insn(3, op_bnez));
            prog_q.push_back(make_insn(3, op_bgez));
        end
        for (k = 0; k < 3; k++) begin
            prog_q.push_back(make_insn(4, op_load));
            prog_q.push_back(make_insn(4, op_store));
        end
        // Every dropped opcode is followed by an instruction that must decode normally
        for (k = 0; k < 3; k++) begin
            prog_q.push_back(make_insn(5, (k == 0) ? 4'd0 : (k == 1) ? 4'd1 : 4'd9));
            prog_q.push_back(make_insn(5, op_add_rr));
        end
    endtask

    // Called on a falling edge, returns on the next one after the byte is taken
    task automatic send_byte(logic [byte_w-1:0] b);
        while (!busy_fetch) begin
            @(negedge clk);
        end
        byte_in = b;
        @(negedge clk);
    endtask

    task automatic run_insn(insn_rec_t rec);
        word_q_t words;
        int      i;
        words = expected_words(rec);
        foreach (words[j]) begin
            exp_q.push_back(words[j]);
            tag_q.push_back(int'(rec.test));
        end
        for (i = 0; i < insn_length(rec.bytes[7:4]); i++) begin
            send_byte(rec.bytes[i*byte_w +: byte_w]);
        end
        if (rec.bytes[7:4] == op_load) begin
            // Decode cycle, then the low and high capture steps
            byte_in = 8'($urandom);
            @(negedge clk);
            byte_in = rec.load_lo;
            @(negedge clk);
            byte_in = rec.load_hi;
            @(negedge clk);
        end
    endtask

    ////////////////////
    // Compare and timeout
    ////////////////////

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            check_en <= 1'b0;
        end else begin
            check_en <= 1'b1;
        end
    end

    always @(negedge clk) begin
        if (check_en && exp_q.size() > 0) begin
            exp_word = exp_q.pop_front();
            exp_tag  = tag_q.pop_front();
            checks[exp_tag]++;
            assert (ctl === exp_word) else begin
                $display("MISMATCH at %0t ns: test %0d ctl %h expected %h",
                         $time, exp_tag + 1, ctl, exp_word);
                errors[exp_tag]++;
            end
            if (tag_q.size() == 0 || tag_q[0] != exp_tag) begin
                $display("Test %0d %s done: %0d checks, %0d errors",
                         exp_tag + 1, test_names[exp_tag], checks[exp_tag], errors[exp_tag]);
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        int total_checks;
        int total_errors;
        void'($urandom(32'had41));
        reset         = 1'b1;
        byte_in       = '0;
        test_names[0] = "reset_fetch";
        test_names[1] = "alu_reg";
        test_names[2] = "alu_imm";
        test_names[3] = "branch";
        test_names[4] = "load_store";
        test_names[5] = "dropped_ops";
        foreach (checks[i]) begin
            checks[i] = 0;
            errors[i] = 0;
        end
        build_program();
        cycle_limit = 12 * prog_q.size() + 100;
        repeat (4) begin
            @(negedge clk);
            checks[0]++;
            assert (ctl === '0) else begin
                $display("MISMATCH at %0t ns: ctl %h during reset", $time, ctl);
                errors[0]++;
            end
            assert (busy_fetch === 1'b1) else begin
                $display("Error at %0t ns: busy_fetch is low during reset", $time);
                errors[0]++;
            end
        end
        reset = 1'b0;
        foreach (prog_q[i]) begin
            run_insn(prog_q[i]);
        end
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        total_checks = 0;
        total_errors = 0;
        foreach (checks[i]) begin
            total_checks += checks[i];
            total_errors += errors[i];
        end
        $display("Summary: %0d instructions, %0d checks, %0d errors",
                 prog_q.size(), total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== cpu_ctl_top.sv ====
`timescale 1ns/1ns

module cpu_ctl_top import cpu_ctl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [byte_w-1:0] byte_in,
    output ctl_word_t         ctl,
    output logic              busy_fetch
);

    insn_word_t insn;
    logic       insn_done;
    step_plan_t plan;
    logic       plan_valid;
    step_t      step;
    logic       step_busy;
    ctl_word_t  word;

    insn_fetch fetch_i (
        .clk        (clk),
        .reset      (reset),
        .byte_in    (byte_in),
        .step_busy  (step_busy),
        .insn       (insn),
        .insn_done  (insn_done),
        .busy_fetch (busy_fetch)
    );

    insn_decode decode_i (
        .clk        (clk),
        .reset      (reset),
        .insn       (insn),
        .insn_done  (insn_done),
        .plan       (plan),
        .plan_valid (plan_valid)
    );

    step_execute execute_i (
        .clk        (clk),
        .reset      (reset),
        .plan       (plan),
        .plan_valid (plan_valid),
        .step       (step),
        .step_busy  (step_busy),
        .word       (word)
    );

    // Load data shares the byte input with instruction fetch
    ctl_result result_i (
        .clk     (clk),
        .reset   (reset),
        .step    (step),
        .word    (word),
        .byte_in (byte_in),
        .ctl     (ctl)
    );

endmodule

// ==== ctl_result.sv ====
`timescale 1ns/1ns

module ctl_result import cpu_ctl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  step_t             step,
    input  ctl_word_t         word,
    input  logic [byte_w-1:0] byte_in,
    output ctl_word_t         ctl
);

    logic [data_w-1:0] scratch_q;
    ctl_word_t         ctl_d;

    always_comb begin
        ctl_d = word;
        if (step == st_load_wb) begin
            ctl_d.immediate = scratch_q;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctl <= '0;
        end else begin
            ctl <= ctl_d;
        end
    end

    // Memory returns the low byte first, then the high byte
    always_ff @(posedge clk) begin
        if (step == st_load_lo) begin
            scratch_q[byte_w-1:0] <= byte_in;
        end
        if (step == st_load_hi) begin
            scratch_q[data_w-1:byte_w] <= byte_in;
        end
    end

    // The writeback word carries the two bytes seen during the capture steps
    a_load_value: assert property (@(posedge clk) disable iff (reset)
        step == st_load_lo ##1 step == st_load_hi ##1 step == st_load_wb
        |=> ctl.immediate == {$past(byte_in, 2), $past(byte_in, 3)});

endmodule

// ==== step_execute.sv ====
`timescale 1ns/1ns

module step_execute import cpu_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  step_plan_t plan,
    input  logic       plan_valid,
    output step_t      step,
    output logic       step_busy,
    output ctl_word_t  word
);

    step_t      cur_q;
    logic [1:0] left_q;
    logic       run_q;

    // Only the memory instructions have more than one step
    function automatic step_t next_step(step_t s);
        case (s)
            st_load_lo:  return st_load_hi;
            st_load_hi:  return st_load_wb;
            st_store_lo: return st_store_hi;
            default:     return st_idle;
        endcase
    endfunction

    ////////////////////
    // Step sequencing
    ////////////////////

    // The plan_valid cycle is the decode cycle, plan steps follow it
    always_comb begin
        if (run_q) begin
            step = cur_q;
        end else if (plan_valid) begin
            step = st_decode;
        end else begin
            step = st_fetch;
        end
    end

    assign step_busy = run_q || plan_valid;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_q  <= 1'b0;
            cur_q  <= st_idle;
            left_q <= 2'd0;
        end else if (run_q) begin
            if (left_q == 2'd0) begin
                run_q <= 1'b0;
            end else begin
                cur_q  <= next_step(cur_q);
                left_q <= left_q - 2'd1;
            end
        end else if (plan_valid) begin
            run_q  <= 1'b1;
            cur_q  <= plan.first_step;
            left_q <= plan.step_cnt - 2'd1;
        end
    end

    ////////////////////
    // Control word
    ////////////////////

    always_comb begin
        word = '0;
        case (step)
            st_fetch: begin
                word.write_en  = num_regs'(1);
                word.alu_op    = alu_add;
                word.output_en = oe_w'(1) << bus_a;
                word.ctl_out   = steer_fetch;
                word.immediate = fetch_imm;
            end
            st_alu_rr, st_alu_ri, st_branch: begin
                word.write_en       = plan.write_oh;
                word.alu_op         = plan.alu_op;
                word.alu_logic_func = plan.logic_func;
                word.output_en      = plan.output_en;
                word.ctl_out        = (step == st_alu_rr) ? steer_rr : steer_ri;
                word.immediate      = plan.immediate;
            end
            st_mov_ri: begin
                word.write_en  = plan.write_oh;
                word.ctl_out   = steer_imm_to_reg;
                word.immediate = plan.immediate;
            end
            st_load_lo, st_load_hi: begin
                word.alu_op     = (step == st_load_lo) ? alu_add : alu_add_carry;
                word.output_en  = plan.output_en;
                word.ctl_out    = steer_load_addr;
                word.immediate2 = plan.immediate2;
            end
            st_load_wb: begin
                // The loaded value is put into the immediate by the output stage
                word.write_en = plan.write_oh;
                word.ctl_out  = steer_imm_to_reg;
            end
            st_store_lo, st_store_hi: begin
                word.data_write_en = 1'b1;
                word.alu_op        = (step == st_store_lo) ? alu_add : alu_add_carry;
                word.output_en     = plan.output_en;
                word.ctl_out       = (step == st_store_lo) ? steer_store_lo : steer_store_hi;
                word.immediate     = plan.immediate;
            end
            // Decode and idle steps leave the word at zero
            default: ;
        endcase
    end

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        $onehot0(word.write_en));

    // A memory write must come from a store that the decoder latched
    a_store_only: assert property (@(posedge clk) disable iff (reset)
        word.data_write_en |-> run_q && plan.opcode == op_store);

endmodule

// ==== insn_decode.sv ====
`timescale 1ns/1ns

module insn_decode import cpu_ctl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  insn_word_t insn,
    input  logic       insn_done,
    output step_plan_t plan,
    output logic       plan_valid
);

    insn_rr_t        rr;
    insn_ri_t        ri;
    logic [op_w-1:0] op;
    step_plan_t      plan_d;

    function automatic logic [num_regs-1:0] reg_onehot(logic [reg_sel_w-1:0] sel);
        return num_regs'(1) << sel;
    endfunction

    // One enable bit inside the three-bit group of a register
    function automatic logic [oe_w-1:0] bus_enable(logic [reg_sel_w-1:0] sel, int bus);
        return oe_w'(1) << (sel * oe_bits_per_reg + bus);
    endfunction

    assign rr = insn.rr_view;
    assign ri = insn.ri_view;
    assign op = rr.opcode;

    always_comb begin
        plan_d            = '0;
        plan_d.opcode     = op;
        plan_d.first_step = st_idle;
        plan_d.step_cnt   = 2'd1;
        case (op)
            op_lfun_rr: begin
                plan_d.first_step = st_alu_rr;
                plan_d.write_oh   = reg_onehot(rr.reg_a);
                plan_d.output_en  = bus_enable(rr.reg_a, bus_a) | bus_enable(rr.reg_b, bus_b);
                plan_d.alu_op     = alu_logic;
                plan_d.logic_func = rr.reg_c;
            end
            op_add_rr, op_sub_rr, op_rot_rr: begin
                plan_d.first_step = st_alu_rr;
                plan_d.write_oh   = reg_onehot(rr.reg_b);
                plan_d.output_en  = bus_enable(rr.reg_b, bus_a) | bus_enable(rr.reg_c, bus_b);
                plan_d.alu_op     = (op == op_add_rr) ? alu_add :
                                    (op == op_sub_rr) ? alu_sub : alu_rot;
                plan_d.logic_func = rr.reg_c;
            end
            op_rot_ri: begin
                // The rotate amount is the nibble in the reg_c slot
                plan_d.first_step = st_alu_ri;
                plan_d.write_oh   = reg_onehot(ri.reg_a);
                plan_d.output_en  = bus_enable(ri.reg_a, bus_a);
                plan_d.alu_op     = alu_rot;
                plan_d.immediate  = data_w'(rr.reg_c);
            end
            op_add_ri: begin
                plan_d.first_step = st_alu_ri;
                plan_d.write_oh   = reg_onehot(ri.reg_a);
                plan_d.output_en  = bus_enable(ri.reg_a, bus_a);
                plan_d.alu_op     = alu_add;
                plan_d.immediate  = ri.lo_imm;
            end
            op_mov_ri: begin
                plan_d.first_step = st_mov_ri;
                plan_d.write_oh   = reg_onehot(ri.reg_a);
                plan_d.immediate  = ri.lo_imm;
            end
            op_lfun_ri: begin
                plan_d.first_step = st_alu_ri;
                plan_d.write_oh   = reg_onehot(rr.reg_b);
                plan_d.output_en  = bus_enable(rr.reg_b, bus_a);
                plan_d.alu_op     = alu_logic;
                plan_d.logic_func = rr.reg_c;
                plan_d.immediate  = rr.hi_imm;
            end
            op_bez, op_bnez, op_bgez: begin
                // Target is reg_c plus offset, the tested value rides on the C bus
                plan_d.first_step = st_branch;
                plan_d.write_oh   = reg_onehot('0);
                plan_d.output_en  = bus_enable(rr.reg_c, bus_a) | bus_enable(rr.reg_b, bus_c);
                plan_d.alu_op     = (op == op_bez)  ? alu_bez :
                                    (op == op_bnez) ? alu_bnez : alu_bgez;
                plan_d.immediate  = rr.hi_imm;
            end
            op_load: begin
                plan_d.first_step = st_load_lo;
                plan_d.step_cnt   = 2'd3;
                plan_d.write_oh   = reg_onehot(rr.reg_b);
                plan_d.output_en  = bus_enable(rr.reg_c, bus_a);
                plan_d.immediate2 = rr.hi_imm;
            end
            op_store: begin
                plan_d.first_step = st_store_lo;
                plan_d.step_cnt   = 2'd2;
                plan_d.output_en  = bus_enable(rr.reg_b, bus_a) | bus_enable(rr.reg_c, bus_b);
                plan_d.immediate  = rr.hi_imm;
            end
            // Unsupported opcodes keep the idle plan
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            plan_valid <= 1'b0;
        end else begin
            plan_valid <= insn_done;
        end
    end

    always_ff @(posedge clk) begin
        if (insn_done) begin
            plan <= plan_d;
        end
    end

endmodule

// ==== insn_fetch.sv ====
`timescale 1ns/1ns

module insn_fetch import cpu_ctl_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [byte_w-1:0] byte_in,
    input  logic              step_busy,
    output insn_word_t        insn,
    output logic              insn_done,
    output logic              busy_fetch
);

    logic [insn_w-1:0] bytes_q;
    logic [insn_w-1:0] bytes_d;
    logic [1:0]        count_q;

    // Index of the last byte, from the length class of the opcode
    function automatic logic [1:0] last_index(logic [op_w-1:0] opcode);
        if (opcode < op_lfun_rr) begin
            return 2'd0;
        end else if (opcode < op_add_ri) begin
            return 2'd1;
        end else if (opcode < op_lfun_ri) begin
            return 2'd2;
        end
        return 2'd3;
    endfunction

    assign busy_fetch = !step_busy;

    // The byte on the input is merged in right away so the opcode of a
    // first byte is visible in the same cycle
    always_comb begin
        bytes_d = bytes_q;
        if (count_q == 2'd0) begin
            bytes_d = '0;
        end
        bytes_d[count_q*byte_w +: byte_w] = byte_in;
    end

    assign insn = bytes_d;

    // High in the cycle whose byte completes the instruction
    assign insn_done = busy_fetch && (count_q == last_index(insn.rr_view.opcode));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count_q <= 2'd0;
        end else if (busy_fetch) begin
            count_q <= insn_done ? 2'd0 : count_q + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (busy_fetch) begin
            bytes_q <= bytes_d;
        end
    end

    // The sequencer must take over in the cycle right after the last byte
    a_done_hand_off: assert property (@(posedge clk) disable iff (reset)
        insn_done |-> !step_busy ##1 step_busy);

endmodule

// ==== cpu_ctl_pkg.sv ====
package cpu_ctl_pkg;

    ////////////////////
    // Widths and sizes
    ////////////////////

    localparam int data_w          = 16;
    localparam int byte_w          = 8;
    localparam int insn_w          = 4 * byte_w;
    localparam int num_regs        = 16;
    localparam int reg_sel_w       = 4;
    localparam int op_w            = 4;
    localparam int oe_bits_per_reg = 3;
    localparam int oe_w            = num_regs * oe_bits_per_reg;
    localparam int ctl_steer_w     = 11;
    localparam int alu_op_w        = 3;

    // Bit position of each bus inside a register's enable group
    localparam int bus_a = 0;
    localparam int bus_b = 1;
    localparam int bus_c = 2;

    ////////////////////
    // Opcodes
    ////////////////////

    // Codes 0, 1 and 9 are not decoded and run as an idle step
    localparam logic [op_w-1:0] op_lfun_rr = 4'd2;
    localparam logic [op_w-1:0] op_add_rr  = 4'd3;
    localparam logic [op_w-1:0] op_sub_rr  = 4'd4;
    localparam logic [op_w-1:0] op_rot_rr  = 4'd5;
    localparam logic [op_w-1:0] op_rot_ri  = 4'd6;
    localparam logic [op_w-1:0] op_add_ri  = 4'd7;
    localparam logic [op_w-1:0] op_mov_ri  = 4'd8;
    localparam logic [op_w-1:0] op_lfun_ri = 4'd10;
    localparam logic [op_w-1:0] op_bez     = 4'd11;
    localparam logic [op_w-1:0] op_bnez    = 4'd12;
    localparam logic [op_w-1:0] op_bgez    = 4'd13;
    localparam logic [op_w-1:0] op_load    = 4'd14;
    localparam logic [op_w-1:0] op_store   = 4'd15;

    ////////////////////
    // ALU operations
    ////////////////////

    localparam logic [alu_op_w-1:0] alu_add       = 3'd0;
    localparam logic [alu_op_w-1:0] alu_add_carry = 3'd1;
    localparam logic [alu_op_w-1:0] alu_sub       = 3'd2;
    localparam logic [alu_op_w-1:0] alu_rot       = 3'd3;
    localparam logic [alu_op_w-1:0] alu_logic     = 3'd4;
    localparam logic [alu_op_w-1:0] alu_bez       = 3'd5;
    localparam logic [alu_op_w-1:0] alu_bnez      = 3'd6;
    localparam logic [alu_op_w-1:0] alu_bgez      = 3'd7;

    ////////////////////
    // Datapath steering
    ////////////////////

    // PC on the address bus, PC plus one back into PC
    localparam logic [ctl_steer_w-1:0] steer_fetch      = 11'b00010010101;
    localparam logic [ctl_steer_w-1:0] steer_rr         = 11'b00010000011;
    localparam logic [ctl_steer_w-1:0] steer_ri         = 11'b00010000101;
    localparam logic [ctl_steer_w-1:0] steer_imm_to_reg = 11'b00101000000;
    localparam logic [ctl_steer_w-1:0] steer_load_addr  = 11'b00000101001;
    localparam logic [ctl_steer_w-1:0] steer_store_lo   = 11'b01000100101;
    localparam logic [ctl_steer_w-1:0] steer_store_hi   = 11'b10000100101;

    localparam logic [data_w-1:0] fetch_imm = 16'd1;

    ////////////////////
    // Types
    ////////////////////

    typedef enum logic [3:0] {
        st_fetch,
        st_decode,
        st_alu_rr,
        st_alu_ri,
        st_mov_ri,
        st_branch,
        st_load_lo,
        st_load_hi,
        st_load_wb,
        st_store_lo,
        st_store_hi,
        st_idle
    } step_t;

    // Register form, with a 16-bit immediate in the top half for the long forms
    typedef struct packed {
        logic [data_w-1:0]    hi_imm;
        logic [reg_sel_w-1:0] reg_b;
        logic [reg_sel_w-1:0] reg_c;
        logic [op_w-1:0]      opcode;
        logic [reg_sel_w-1:0] reg_a;
    } insn_rr_t;

    // Three-byte immediate form
    typedef struct packed {
        logic [byte_w-1:0]    spare;
        logic [data_w-1:0]    lo_imm;
        logic [op_w-1:0]      opcode;
        logic [reg_sel_w-1:0] reg_a;
    } insn_ri_t;

    typedef union packed {
        insn_rr_t rr_view;
        insn_ri_t ri_view;
    } insn_word_t;

    typedef struct packed {
        logic [op_w-1:0]     opcode;
        step_t               first_step;
        logic [1:0]          step_cnt;
        logic [num_regs-1:0] write_oh;
        logic [oe_w-1:0]     output_en;
        logic [data_w-1:0]   immediate;
        logic [data_w-1:0]   immediate2;
        logic [alu_op_w-1:0] alu_op;
        logic [3:0]          logic_func;
    } step_plan_t;

    typedef struct packed {
        logic [num_regs-1:0]    write_en;
        logic                   data_write_en;
        logic [alu_op_w-1:0]    alu_op;
        logic [3:0]             alu_logic_func;
        logic [oe_w-1:0]        output_en;
        logic [ctl_steer_w-1:0] ctl_out;
        logic [data_w-1:0]      immediate;
        logic [data_w-1:0]      immediate2;
    } ctl_word_t;

endpackage
